// ==== build.f ====
src/pkt_pkg.sv
src/packet_sram.sv
src/replay_fifo.sv
src/packet_cntl.sv
src/packet_replay_top.sv
testbench/tb_packet_replay.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_packet_replay
FILELIST  = build.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_packet_replay.sv ====
`timescale 1ns/1ps

// testbench for the packet replay buffer
// random producer traffic and consumer pops from a fixed seed
// a queue model of accepted packets is checked against every popped word

module tb_packet_replay
    import pkt_pkg::*;
();

    localparam int W           = DEF_PACKET_W;
    localparam int N           = DEF_NUM_EDGE_PE;
    localparam int MAX_LINES   = DEF_MAX_LINES;
    localparam int FIFO_DEPTH  = DEF_FIFO_DEPTH;
    localparam int CLK_PERIOD  = 10;

    // test lengths in cycles
    localparam int RESET_CYCLES  = 5;
    localparam int ORDER_CYCLES  = 200;
    localparam int ARB_CYCLES    = 150;
    localparam int FILL_CYCLES   = 40;
    localparam int STALL_CYCLES  = 200;
    localparam int DONE_CYCLES   = 40;
    localparam int REPLAY_CYCLES = 150;
    localparam int DRAIN_BOUND   = 4 * MAX_LINES;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + ORDER_CYCLES + ARB_CYCLES + FILL_CYCLES
                                   + STALL_CYCLES + DONE_CYCLES + REPLAY_CYCLES
                                   + 4 * DRAIN_BOUND + 2 * MAX_LINES + 7;
    localparam int WATCHDOG_NS   = (TOTAL_CYCLES + 200) * CLK_PERIOD;

    typedef enum {M_IDLE, M_RUN, M_DONE} model_state_t;

    logic                clk;
    logic                reset;
    logic                dp_valid;
    logic [W-1:0]        dp_packet;
    logic [N-1:0]        edge_valid;
    logic [N*W-1:0]      edge_packet;
    logic                cntl_done;
    logic                replay_iter_flag;
    logic                fifo_stall;
    logic                out_pop;
    logic                out_valid;
    logic [W-1:0]        out_data;

    // accepted packets not yet popped, oldest first
    logic [W-1:0]        model_q[$];
    model_state_t        mstate;
    logic                stall_lvl;

    packet_replay_top #(
        .PACKET_W   (W),
        .NUM_EDGE_PE(N),
        .MAX_LINES  (MAX_LINES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_packet_replay_top (
        .clk             (clk),
        .reset           (reset),
        .dp_valid        (dp_valid),
        .dp_packet       (dp_packet),
        .edge_valid      (edge_valid),
        .edge_packet     (edge_packet),
        .cntl_done       (cntl_done),
        .replay_iter_flag(replay_iter_flag),
        .fifo_stall      (fifo_stall),
        .out_pop         (out_pop),
        .out_valid       (out_valid),
        .out_data        (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [W-1:0] actual,
                               input logic [W-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s actual 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    // the highest-numbered valid edge PE wins
    function automatic logic [W-1:0] highest_edge(input logic [N-1:0] ev,
                                                  input logic [N*W-1:0] ep);
        logic [W-1:0] sel;
        logic         found;
        sel   = '0;
        found = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (ev[i] && !found) begin
                sel   = ep[i*W +: W];
                found = 1'b1;
            end
        end
        return sel;
    endfunction

    // starts at a falling edge, drives one clock cycle, ends at the next falling edge
    task automatic cycle(input logic dpv, input logic [W-1:0] dpp, input logic [N-1:0] ev,
                         input logic [N*W-1:0] ep, input logic done, input logic iter,
                         input logic stall, input logic pop);
        logic room;
        if (pop && out_valid) begin
            if (model_q.size() == 0) begin
                fail_run("out_valid was high with no accepted packet left to match");
            end else begin
                check_value("out_data", out_data, model_q.pop_front());
            end
        end
        // keep unread lines below the line buffer depth
        room             = (model_q.size() < MAX_LINES - 1);
        dp_valid         = dpv && room;
        dp_packet        = dpp;
        edge_valid       = room ? ev : '0;
        edge_packet      = ep;
        cntl_done        = done;
        replay_iter_flag = iter;
        fifo_stall       = stall;
        out_pop          = pop;
        if (mstate == M_RUN && !done && !iter && room) begin
            if (dpv) begin
                model_q.push_back(dpp);
            end else if (ev != '0) begin
                model_q.push_back(highest_edge(ev, ep));
            end
        end
        if (iter) begin
            model_q.delete();
            mstate = M_IDLE;
        end else if (mstate == M_IDLE) begin
            mstate = M_RUN;
        end else if (mstate == M_RUN && done) begin
            mstate = M_DONE;
        end
        @(negedge clk);
    endtask

    task automatic random_cycle(input logic use_edge, input logic pop, input logic stall,
                                input logic done, input logic iter);
        logic           dpv;
        logic [W-1:0]   dpp;
        logic [N-1:0]   ev;
        logic [N*W-1:0] ep;
        // fewer datapath packets when edges are in play, so edge-only cycles occur
        dpv = use_edge ? ($urandom_range(3) == 0) : 1'($urandom_range(1));
        dpp = W'($urandom);
        ev  = use_edge ? N'($urandom) : '0;
        for (int i = 0; i < N; i++) begin
            ep[i*W +: W] = W'($urandom);
        end
        cycle(dpv, dpp, ev, ep, done, iter, stall, pop);
    endtask

    task automatic drain();
        while (model_q.size() != 0) begin
            cycle(1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        check_value("out_valid", W'(out_valid), W'(0));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: simulation timed out after %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(14));
        clk              = 1'b0;
        reset            = 1'b1;
        dp_valid         = 1'b0;
        dp_packet        = '0;
        edge_valid       = '0;
        edge_packet      = '0;
        cntl_done        = 1'b0;
        replay_iter_flag = 1'b0;
        fifo_stall       = 1'b0;
        out_pop          = 1'b0;
        stall_lvl        = 1'b0;
        mstate           = M_IDLE;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("out_valid", W'(out_valid), W'(0));
        end
        reset = 1'b0;
        cycle(1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        check_value("out_valid", W'(out_valid), W'(0));

        // datapath only, random pops
        repeat (ORDER_CYCLES) random_cycle(1'b0, 1'($urandom_range(1)), 1'b0, 1'b0, 1'b0);
        drain();

        // datapath and edge PEs competing
        repeat (ARB_CYCLES) random_cycle(1'b1, 1'($urandom_range(1)), 1'b0, 1'b0, 1'b0);
        drain();

        // no pops, FIFO fills while writes continue
        repeat (FILL_CYCLES) random_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        check_value("out_valid", W'(out_valid), W'(1));
        check_value("packets beyond FIFO depth", W'(model_q.size() > FIFO_DEPTH), W'(1));

        // random stall stretches
        repeat (STALL_CYCLES) begin
            if ($urandom_range(7) == 0) begin
                stall_lvl = !stall_lvl;
            end
            random_cycle(1'b1, 1'($urandom_range(1)), stall_lvl, 1'b0, 1'b0);
        end
        drain();

        // packets moved into the FIFO before cntl_done must still come out
        repeat (5) cycle(1'b1, W'($urandom), '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (2 * MAX_LINES) cycle(1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        random_cycle(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        repeat (DONE_CYCLES) random_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        check_value("packets left unpopped", W'(model_q.size()), W'(0));
        check_value("out_valid", W'(out_valid), W'(0));

        // new iteration from line 0
        random_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (REPLAY_CYCLES) random_cycle(1'b1, 1'($urandom_range(1)), 1'b0, 1'b0, 1'b0);
        drain();

        $display("Test OK");
        $finish;
    end

endmodule

// ==== src/packet_replay_top.sv ====
`timescale 1ns/1ps

// packet replay buffer top level
// controller, single-port line buffer and first-word-fall-through
// output FIFO, sized from the parameters below

module packet_replay_top
    import pkt_pkg::*;
#(
    parameter int PACKET_W    = DEF_PACKET_W,
    parameter int NUM_EDGE_PE = DEF_NUM_EDGE_PE,
    parameter int MAX_LINES   = DEF_MAX_LINES,
    parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            dp_valid,
    input  logic [PACKET_W-1:0]             dp_packet,
    input  logic [NUM_EDGE_PE-1:0]          edge_valid,
    input  logic [NUM_EDGE_PE*PACKET_W-1:0] edge_packet,
    input  logic                            cntl_done,
    input  logic                            replay_iter_flag,
    input  logic                            fifo_stall,
    input  logic                            out_pop,
    output logic                            out_valid,
    output logic [PACKET_W-1:0]             out_data
);

    localparam int AW = (MAX_LINES > 1) ? $clog2(MAX_LINES) : 1;

    logic                sram_wen;
    logic [AW-1:0]       sram_addr;
    logic [PACKET_W-1:0] sram_wdata;
    logic [PACKET_W-1:0] sram_rdata;
    logic                fifo_wr_en;
    logic [PACKET_W-1:0] fifo_wr_data;
    logic                full;

    packet_cntl #(
        .PACKET_W   (PACKET_W),
        .NUM_EDGE_PE(NUM_EDGE_PE),
        .MAX_LINES  (MAX_LINES)
    ) u_cntl (
        .clk             (clk),
        .reset           (reset),
        .replay_iter_flag(replay_iter_flag),
        .cntl_done       (cntl_done),
        .fifo_stall      (fifo_stall),
        .full            (full),
        .dp_valid        (dp_valid),
        .dp_packet       (dp_packet),
        .edge_valid      (edge_valid),
        .edge_packet     (edge_packet),
        .sram_wen        (sram_wen),
        .sram_addr       (sram_addr),
        .sram_wdata      (sram_wdata),
        .sram_rdata      (sram_rdata),
        .fifo_wr_en      (fifo_wr_en),
        .fifo_wr_data    (fifo_wr_data)
    );

    packet_sram #(
        .PACKET_W (PACKET_W),
        .MAX_LINES(MAX_LINES)
    ) u_sram (
        .clk  (clk),
        .wen  (sram_wen),
        .addr (sram_addr),
        .wdata(sram_wdata),
        .rdata(sram_rdata)
    );

    replay_fifo #(
        .PACKET_W  (PACKET_W),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (fifo_wr_en),
        .wr_data  (fifo_wr_data),
        .full     (full),
        .pop      (out_pop),
        .out_valid(out_valid),
        .out_data (out_data)
    );

endmodule

// ==== src/packet_cntl.sv ====
`timescale 1ns/1ps

// packet replay controller
// stores datapath and edge PE packets into the line buffer in arrival order
// and, in cycles with no write, reads stored lines back oldest first
// for the output FIFO. datapath wins over edge PEs, and among edge PEs
// the highest-numbered valid one is stored

module packet_cntl
    import pkt_pkg::*;
#(
    parameter int PACKET_W    = DEF_PACKET_W,
    parameter int NUM_EDGE_PE = DEF_NUM_EDGE_PE,
    parameter int MAX_LINES   = DEF_MAX_LINES
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         replay_iter_flag,
    input  logic                                         cntl_done,
    input  logic                                         fifo_stall,
    input  logic                                         full,
    input  logic                                         dp_valid,
    input  logic [PACKET_W-1:0]                          dp_packet,
    input  logic [NUM_EDGE_PE-1:0]                       edge_valid,
    input  logic [NUM_EDGE_PE*PACKET_W-1:0]              edge_packet,
    output logic                                         sram_wen,
    output logic [((MAX_LINES > 1) ? $clog2(MAX_LINES) : 1)-1:0] sram_addr,
    output logic [PACKET_W-1:0]                          sram_wdata,
    input  logic [PACKET_W-1:0]                          sram_rdata,
    output logic                                         fifo_wr_en,
    output logic [PACKET_W-1:0]                          fifo_wr_data
);

    localparam int AW = (MAX_LINES > 1) ? $clog2(MAX_LINES) : 1;

    cntl_state_t         state;
    cntl_state_t         next_state;
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic                edge_hit;
    logic [PACKET_W-1:0] edge_data;
    logic                accept_en;
    logic                wr_win;
    logic                rd_issue;

    function automatic logic [AW-1:0] next_line(input logic [AW-1:0] ptr);
        next_line = (ptr == AW'(MAX_LINES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // edge arbitration, later loop index overrides earlier ones
    always_comb begin
        edge_hit  = 1'b0;
        edge_data = '0;
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            if (edge_valid[i]) begin
                edge_hit  = 1'b1;
                edge_data = edge_packet[i*PACKET_W +: PACKET_W];
            end
        end
    end

    // packets only land while streaming or held
    assign accept_en = ((state == STREAM) || (state == HOLD)) && !cntl_done
                       && !replay_iter_flag;
    assign wr_win    = accept_en && (dp_valid || edge_hit);

    // read only into a FIFO with room, and never past the write pointer
    assign rd_issue = (state == STREAM) && !wr_win && !full && !fifo_stall
                      && !cntl_done && !replay_iter_flag && (rd_ptr != wr_ptr);

    assign sram_wen     = wr_win;
    assign sram_addr    = wr_win ? wr_ptr : rd_ptr;
    assign sram_wdata   = dp_valid ? dp_packet : edge_data;
    assign fifo_wr_data = sram_rdata;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                next_state = STREAM;
            end
            STREAM: begin
                if (cntl_done) begin
                    next_state = DONE;
                end else if (fifo_stall) begin
                    next_state = HOLD;
                end
            end
            HOLD: begin
                if (cntl_done) begin
                    next_state = DONE;
                end else if (!fifo_stall) begin
                    next_state = STREAM;
                end
            end
            DONE: begin
                // left only through replay_iter_flag or reset
                next_state = DONE;
            end
        endcase
    end

    // a new replay iteration restarts from line 0 like a reset,
    // but the FIFO keeps what it already holds
    always_ff @(posedge clk) begin
        if (reset || replay_iter_flag) begin
            state      <= IDLE;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_wr_en <= 1'b0;
        end else begin
            state <= next_state;
            if (wr_win) begin
                wr_ptr <= next_line(wr_ptr);
            end
            if (rd_issue) begin
                rd_ptr <= next_line(rd_ptr);
            end
            // read data is valid one cycle after the read
            fifo_wr_en <= rd_issue;
        end
    end

    // write pointer never laps the read pointer over unread lines
    a_no_overrun: assert property (
        @(posedge clk) disable iff (reset) wr_win |-> (next_line(wr_ptr) != rd_ptr)
    );

    // no line buffer read reaches the FIFO once done
    a_done_quiet: assert property (
        @(posedge clk) disable iff (reset) (state == DONE) |-> !fifo_wr_en
    );

endmodule

// ==== src/replay_fifo.sv ====
`timescale 1ns/1ps

// output FIFO of the replay buffer
// first-word-fall-through toward the consumer
// full is raised with one slot still free, which absorbs the read
// the controller may already have in flight when it sees full

module replay_fifo
    import pkt_pkg::*;
#(
    parameter int PACKET_W   = DEF_PACKET_W,
    parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_en,
    input  logic [PACKET_W-1:0] wr_data,
    output logic                full,
    input  logic                pop,
    output logic                out_valid,
    output logic [PACKET_W-1:0] out_data
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [PACKET_W-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0]       wr_ptr;
    logic [PW-1:0]       rd_ptr;
    logic [CW-1:0]       count;
    logic                pop_ok;

    function automatic logic [PW-1:0] next_slot(input logic [PW-1:0] ptr);
        next_slot = (ptr == PW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign full      = (count >= CW'(FIFO_DEPTH - 1));

    // pop on an empty FIFO is dropped
    assign pop_ok = pop && out_valid;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_slot(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_slot(rd_ptr);
            end
            count <= count + CW'(wr_en) - CW'(pop_ok);
        end
    end

    // early full must keep the controller's late write from overflowing
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> (count < CW'(FIFO_DEPTH))
    );

endmodule

// ==== src/packet_sram.sv ====
`timescale 1ns/1ps

// single-port packet line buffer
// synchronous write when wen is high, registered read otherwise

module packet_sram
    import pkt_pkg::*;
#(
    parameter int PACKET_W  = DEF_PACKET_W,
    parameter int MAX_LINES = DEF_MAX_LINES
) (
    input  logic                                      clk,
    input  logic                                      wen,
    input  logic [((MAX_LINES > 1) ? $clog2(MAX_LINES) : 1)-1:0] addr,
    input  logic [PACKET_W-1:0]                       wdata,
    output logic [PACKET_W-1:0]                       rdata
);

    logic [PACKET_W-1:0] mem [MAX_LINES];

    // one port, so a write cycle gives no read data
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== src/pkt_pkg.sv ====
// packet replay buffer shared definitions
// default sizes for the top level and the controller state encoding

package pkt_pkg;

    // default packet width in bits
    localparam int DEF_PACKET_W = 32;

    // edge processing elements feeding the buffer
    localparam int DEF_NUM_EDGE_PE = 4;

    // line buffer depth in packets
    localparam int DEF_MAX_LINES = 16;

    // output FIFO depth in packets
    localparam int DEF_FIFO_DEPTH = 8;

    // controller states
    // IDLE   one cycle after reset or a replay restart
    // STREAM writes accepted, reads issued toward the FIFO
    // HOLD   downstream stall, writes only
    // DONE   quiet until the next replay iteration
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        STREAM = 2'd1,
        HOLD   = 2'd2,
        DONE   = 2'd3
    } cntl_state_t;

endpackage
